// File: flist.f
logic/cpuPkg.sv
logic/ctrlIf.sv
logic/pcUnit.sv
logic/instrMem.sv
logic/regFile.sv
logic/controlUnit.sv
logic/execUnit.sv
logic/dataMem.sv
logic/singleCpu.sv
testbench/singleCpuTb.sv

// File: run.sh
#!/bin/bash
# Build and run the testbench with Verilator; exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module singleCpuTb \
    -f flist.f \
    -o simv \
    && ./obj_dir/simv \
    || exit 1

// File: testbench/singleCpuTb.sv
`timescale 1ns/100ps

module singleCpuTb import cpuPkg::*; ();

    localparam int progLen       = 16;
    localparam int traceLen      = 20;
    localparam int timeoutCycles = progLen + traceLen + 20;

    // One expected trace row per executed cycle
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic            valid;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } traceRowT;

    logic                 CLK      = 1'b0;
    logic                 reset    = 1'b1;
    logic                 imemWrEn = 1'b0;
    logic [imemAddrW-1:0] imemAddr = '0;
    logic [xlen-1:0]      imemData = '0;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    logic            wbValid;
    logic [4:0]      wbReg;
    logic [xlen-1:0] wbData;

    logic [xlen-1:0] prog [progLen];
    traceRowT        trace [traceLen];
    int              cycleCount = 0;

    singleCpu singleCpu_i (
        .CLK(CLK), .reset(reset), .imemWrEn(imemWrEn), .imemAddr(imemAddr),
        .imemData(imemData), .pc(pc), .instr(instr), .wbValid(wbValid),
        .wbReg(wbReg), .wbData(wbData)
    );

    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: trace not finished after %0d cycles", cycleCount);
            $display("Result: FAILED");
            $fatal(1, "Simulation stopped by timeout");
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0d ns: %s = %h, expected %h",
                     $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "Check on %s failed", name);
        end
    endtask

    task automatic fillTables();
        prog[0]  = 32'h00600093;    // addi x1, x0, 6
        prog[1]  = 32'hFFD00113;    // addi x2, x0, -3
        prog[2]  = 32'h002081B3;    // add  x3, x1, x2
        prog[3]  = 32'h40208233;    // sub  x4, x1, x2
        prog[4]  = 32'h0020F2B3;    // and  x5, x1, x2
        prog[5]  = 32'h0020E333;    // or   x6, x1, x2
        prog[6]  = 32'h001123B3;    // slt  x7, x2, x1
        prog[7]  = 32'h00402423;    // sw   x4, 8(x0)
        prog[8]  = 32'h00802403;    // lw   x8, 8(x0)
        prog[9]  = 32'h00440463;    // beq  x8, x4, +8
        prog[10] = 32'h06300493;    // addi x9, x0, 99
        prog[11] = 32'h00208463;    // beq  x1, x2, +8
        prog[12] = 32'h0020A533;    // slt  x10, x1, x2
        prog[13] = 32'hFFF18593;    // addi x11, x3, -1
        prog[14] = 32'h00000063;    // beq  x0, x0, 0
        prog[15] = 32'h00100613;    // addi x12, x0, 1

        // pc, wbValid, wbReg, wbData
        trace[0]  = '{32'h00, 1'b1, 5'd1,  32'd6};
        trace[1]  = '{32'h04, 1'b1, 5'd2,  32'hFFFFFFFD};
        trace[2]  = '{32'h08, 1'b1, 5'd3,  32'd3};
        trace[3]  = '{32'h0C, 1'b1, 5'd4,  32'd9};
        trace[4]  = '{32'h10, 1'b1, 5'd5,  32'd4};
        trace[5]  = '{32'h14, 1'b1, 5'd6,  32'hFFFFFFFF};
        trace[6]  = '{32'h18, 1'b1, 5'd7,  32'd1};
        trace[7]  = '{32'h1C, 1'b0, 5'd0,  32'd0};          // sw
        trace[8]  = '{32'h20, 1'b1, 5'd8,  32'd9};          // lw of stored word
        trace[9]  = '{32'h24, 1'b0, 5'd0,  32'd0};          // beq taken
        trace[10] = '{32'h2C, 1'b0, 5'd0,  32'd0};          // beq not taken
        trace[11] = '{32'h30, 1'b1, 5'd10, 32'd0};
        trace[12] = '{32'h34, 1'b1, 5'd11, 32'd2};
        // Self loop from here on
        for (int i = 13; i < traceLen; i++) begin
            trace[i] = '{32'h38, 1'b0, 5'd0, 32'd0};
        end
    endtask

    initial begin
        fillTables();

        // Program load while held in reset
        for (int i = 0; i < progLen; i++) begin
            @(posedge CLK);
            #2;
            imemWrEn = 1'b1;
            imemAddr = imemAddrW'(i);
            imemData = prog[i];
            @(negedge CLK);
            check("pc", pc, 32'h0);
            check("wbValid", 32'(wbValid), 32'h0);
        end
        @(posedge CLK);
        #2;
        imemWrEn = 1'b0;

        repeat (2) begin
            @(negedge CLK);
            check("pc", pc, 32'h0);
            check("wbValid", 32'(wbValid), 32'h0);
            @(posedge CLK);
        end
        #2;
        reset = 1'b0;

        // One row per executed instruction sampled mid cycle
        for (int i = 0; i < traceLen; i++) begin
            @(negedge CLK);
            check("pc", pc, trace[i].pc);
            check("instr", instr, prog[trace[i].pc[5:2]]);
            check("wbValid", 32'(wbValid), 32'(trace[i].valid));
            if (trace[i].valid) begin
                check("wbReg", 32'(wbReg), 32'(trace[i].rd));
                check("wbData", wbData, trace[i].data);
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: logic/singleCpu.sv
`timescale 1ns/100ps

module singleCpu import cpuPkg::*; (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 imemWrEn,
    input  logic [imemAddrW-1:0] imemAddr,
    input  logic [xlen-1:0]      imemData,
    output logic [xlen-1:0]      pc,
    output logic [xlen-1:0]      instr,
    output logic                 wbValid,
    output logic [4:0]           wbReg,
    output logic [xlen-1:0]      wbData
);

    ctrlIf ctrlBus ();

    instrT           instrWord;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] memWrData;
    logic [xlen-1:0] memRdData;
    logic [xlen-1:0] imm;
    logic            branchTaken;

    pcUnit pcUnit_i (
        .CLK(CLK), .reset(reset), .branchTaken(branchTaken), .imm(imm), .pc(pc)
    );

    instrMem instrMem_i (
        .CLK(CLK), .wrEn(imemWrEn), .wrAddr(imemAddr), .wrData(imemData),
        .pc(pc), .instr(instrWord)
    );

    controlUnit controlUnit_i (.reset(reset), .instr(instrWord), .ctrl(ctrlBus));

    // Register indices sit in the same slots for every format used
    regFile regFile_i (
        .CLK(CLK), .reset(reset), .ctrl(ctrlBus),
        .rs1(instrWord.r.rs1), .rs2(instrWord.r.rs2), .rd(instrWord.r.rd),
        .wbData(wbData), .rd1(rd1), .rd2(rd2)
    );

    execUnit execUnit_i (
        .instr(instrWord), .ctrl(ctrlBus), .rd1(rd1), .rd2(rd2),
        .memRdData(memRdData), .aluResult(aluResult), .memWrData(memWrData),
        .wbData(wbData), .imm(imm), .branchTaken(branchTaken)
    );

    dataMem dataMem_i (
        .CLK(CLK), .ctrl(ctrlBus), .addr(aluResult), .wrData(memWrData),
        .rdData(memRdData)
    );

    // Observation ports for the trace
    assign instr   = instrWord;
    assign wbValid = ctrlBus.regWrite;    // Already low during reset
    assign wbReg   = instrWord.r.rd;

endmodule

// File: logic/dataMem.sv
`timescale 1ns/100ps

module dataMem import cpuPkg::*; (
    input  logic            CLK,
    ctrlIf.mem              ctrl,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wrData,
    output logic [xlen-1:0] rdData
);

    logic [xlen-1:0] mem [dmemDepth];
    logic [dmemAddrW-1:0] wordIdx;

    assign wordIdx = addr[dmemAddrW+1:2];

    always_ff @(posedge CLK) begin
        if (ctrl.memWrite) begin
            mem[wordIdx] <= wrData;
        end
    end

    assign rdData = mem[wordIdx];    // Async read for lw

    // Word stores only, inside the array
    storeAddrOk: assert property (
        @(posedge CLK)
        ctrl.memWrite |-> (addr < xlen'(dmemDepth * 4)) && (addr[1:0] == 2'b00)
    ) else $error("Bad store address: %h", addr);

endmodule

// File: logic/execUnit.sv
`timescale 1ns/100ps

module execUnit import cpuPkg::*; (
    input  instrT           instr,
    ctrlIf.exec             ctrl,
    input  logic [xlen-1:0] rd1,
    input  logic [xlen-1:0] rd2,
    input  logic [xlen-1:0] memRdData,
    output logic [xlen-1:0] aluResult,
    output logic [xlen-1:0] memWrData,
    output logic [xlen-1:0] wbData,
    output logic [xlen-1:0] imm,
    output logic            branchTaken
);

    logic [xlen-1:0] immIVal;
    logic [xlen-1:0] immSVal;
    logic [xlen-1:0] immBVal;
    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic            zero;

    // I form, imm[11:0] = funct7 and rs2 slots
    assign immIVal = {{(xlen-12){instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};

    // S form, immHi and immLo back to back
    assign immSVal = {{(xlen-12){instr.sb.immHi[6]}}, instr.sb.immHi, instr.sb.immLo};

    // B form, bit 11 hides in immLo[0] and bit 0 is implicit
    assign immBVal = {
        {(xlen-12){instr.sb.immHi[6]}},
        instr.sb.immLo[0],
        instr.sb.immHi[5:0],
        instr.sb.immLo[4:1],
        1'b0
    };

    always_comb begin
        case (ctrl.immSel)
            immS:    imm = immSVal;
            immB:    imm = immBVal;
            default: imm = immIVal;
        endcase
    end

    assign opA = rd1;
    assign opB = ctrl.aluSrc ? imm : rd2;

    always_comb begin
        case (ctrl.aluOp)
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluSlt:  aluResult = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluResult = opA + opB;
        endcase
    end

    assign zero = (aluResult == '0);
    assign branchTaken = ctrl.branch & zero;    // beq only

    assign memWrData = rd2;    // Store data straight from rs2

    // Loads return memory data, everything else the ALU
    assign wbData = ctrl.memToReg ? memRdData : aluResult;

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/100ps

module controlUnit import cpuPkg::*; (
    input  logic reset,
    input  instrT instr,
    ctrlIf.ctrl  ctrl
);

    aluOpT funct3Op;

    // ALU operation picked by funct3 alone
    always_comb begin
        case (instr.r.funct3)
            3'b010:  funct3Op = aluSlt;
            3'b110:  funct3Op = aluOr;
            3'b111:  funct3Op = aluAnd;
            default: funct3Op = aluAdd;
        endcase
    end

    always_comb begin
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.aluOp    = aluAdd;
        ctrl.immSel   = immI;

        case (instr.r.opcode)
            opReg: begin
                ctrl.regWrite = 1'b1;
                // funct7 bit 5 turns add into sub
                if (instr.r.funct3 == 3'b000 && instr.r.funct7[5]) begin
                    ctrl.aluOp = aluSub;
                end else begin
                    ctrl.aluOp = funct3Op;
                end
            end
            opImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = funct3Op;
            end
            opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;    // Address add, data from memory
            end
            opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSel   = immS;
            end
            opBranch: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;    // Zero result means equal
                ctrl.immSel = immB;
            end
            default: ;
        endcase

        // No architectural writes while held in reset
        if (reset) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

    always_comb begin
        if (!reset) begin
            assert (instr.r.opcode inside {opReg, opImm, opLoad, opStore, opBranch})
                else $error("Unsupported opcode %b", instr.r.opcode);
        end
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/100ps

module regFile import cpuPkg::*; (
    input  logic            CLK,
    input  logic            reset,
    ctrlIf.rf               ctrl,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [xlen-1:0] wbData,
    output logic [xlen-1:0] rd1,
    output logic [xlen-1:0] rd2
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && rd != 5'd0) begin    // x0 never written
            regs[rd] <= wbData;
        end
    end

    // Async reads, old value on a same-cycle write
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    // x0 must read as zero whatever was written back before
    x0ZeroRs1: assert property (
        @(posedge CLK)
        rs1 == 5'd0 |-> rd1 == '0
    ) else $error("x0 read nonzero on rs1: %h", rd1);

    x0ZeroRs2: assert property (
        @(posedge CLK)
        rs2 == 5'd0 |-> rd2 == '0
    ) else $error("x0 read nonzero on rs2: %h", rd2);

endmodule

// File: logic/instrMem.sv
`timescale 1ns/100ps

module instrMem import cpuPkg::*; (
    input  logic                 CLK,
    input  logic                 wrEn,
    input  logic [imemAddrW-1:0] wrAddr,
    input  logic [xlen-1:0]      wrData,
    input  logic [xlen-1:0]      pc,
    output instrT                instr
);

    logic [xlen-1:0] mem [imemDepth];
    logic [imemAddrW-1:0] rdIdx;

    // Program load, one word per clock
    always_ff @(posedge CLK) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    assign rdIdx = pc[imemAddrW+1:2];    // Byte address to word index
    assign instr = mem[rdIdx];

    // PC sits at zero through reset, so this only bites once the core runs
    pcInRange: assert property (
        @(posedge CLK)
        pc < xlen'(imemDepth * 4)
    ) else $error("Fetch outside instruction memory: %h", pc);

endmodule

// File: logic/pcUnit.sv
`timescale 1ns/100ps

module pcUnit import cpuPkg::*; (
    input  logic            CLK,
    input  logic            reset,
    input  logic            branchTaken,
    input  logic [xlen-1:0] imm,
    output logic [xlen-1:0] pc
);

    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] pcTarget;
    logic [xlen-1:0] pcNext;

    assign pcPlus4  = pc + xlen'(4);
    assign pcTarget = pc + imm;     // B immediate already carries bit 0 = 0

    // Taken branch wins over fall-through
    assign pcNext = branchTaken ? pcTarget : pcPlus4;

    always_ff @(posedge CLK) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Branch offsets from decode must keep the fetch address on a word boundary
    pcAligned: assert property (
        @(posedge CLK) disable iff (reset)
        pc[1:0] == 2'b00
    ) else $error("PC not word aligned: %h", pc);

endmodule

// File: logic/ctrlIf.sv
`timescale 1ns/100ps

interface ctrlIf import cpuPkg::*; ();

    logic       regWrite;
    logic       aluSrc;     // Second ALU operand is the immediate
    logic       memWrite;
    logic       memToReg;
    logic       branch;
    aluOpT      aluOp;
    logic [1:0] immSel;     // immI, immS or immB

    modport ctrl (output regWrite, aluSrc, memWrite, memToReg, branch, aluOp, immSel);

    modport exec (input aluSrc, memToReg, branch, aluOp, immSel);

    modport rf (input regWrite);

    modport mem (input memWrite);

endinterface

// File: logic/cpuPkg.sv
package cpuPkg;

    localparam int xlen = 32;
    localparam int imemDepth = 64;
    localparam int dmemDepth = 64;
    localparam int imemAddrW = $clog2(imemDepth);
    localparam int dmemAddrW = $clog2(dmemDepth);

    // Immediate form selects
    localparam logic [1:0] immI = 2'd0;
    localparam logic [1:0] immS = 2'd1;
    localparam logic [1:0] immB = 2'd2;

    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

    // R and I formats share this view, imm[11:0] sits in funct7 and rs2
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rFmtT;

    // S and B formats split the immediate around rs2/rs1
    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        opcodeT     opcode;
    } sbFmtT;

    typedef union packed {
        rFmtT  r;
        sbFmtT sb;
    } instrT;

endpackage
